// File: dv/line_buffer_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer_asserts (
    input wire                 clk,
    input wire                 arst_n,
    input wire                 wb_cyc,
    input wire                 wb_stb,
    input wire                 wb_ack,
    input wire                 line_req,
    input wire                 line_req_ready,
    input wire                 line_valid,
    input wire                 line_ready,
    input wire mem_pkg::line_t line_data
);

    int         fail_cnt = 0;
    logic       stb_open;
    logic       stb_start;
    logic       accept;
    logic       consume;
    logic [2:0] outstanding;

    // ==================================================
    // Protocol tracking
    // ==================================================

    // A strobe is open from its first cycle until its ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stb_open <= 1'b0;
        end else begin
            stb_open <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    assign stb_start = wb_cyc && wb_stb && !stb_open;
    assign accept    = line_req && line_req_ready;
    assign consume   = line_valid && line_ready;

    // Accepted lines that are still in flight or held
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 3'd0;
        end else begin
            outstanding <= outstanding + 3'(accept) - 3'(consume);
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    reset_values: assert property (@(posedge clk)
        !arst_n |-> !wb_ack && !line_valid && line_req_ready)
    else begin
        fail_cnt++;
        $error("Outputs are not at their reset values during reset");
    end

    // Any ack belongs to a live strobe that started two cycles earlier
    ack_needs_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |-> wb_cyc && wb_stb && $past(stb_start, 2))
    else begin
        fail_cnt++;
        $error("Ack seen outside the third cycle of a strobe");
    end

    // Ack lands in the third cycle of the strobe
    ack_third_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        stb_start |-> !wb_ack ##1 !wb_ack ##1 wb_ack)
    else begin
        fail_cnt++;
        $error("Ack missing in the third cycle of a strobe");
    end

    ack_single: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
    else begin
        fail_cnt++;
        $error("Ack held for more than one cycle");
    end

    ready_credit: assert property (@(posedge clk) disable iff (!arst_n)
        line_req_ready == (outstanding < 3'd2))
    else begin
        fail_cnt++;
        $error("FAILED line_req_ready got %h expected %h",
            $sampled(line_req_ready), $sampled(outstanding < 3'd2));
    end

    valid_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
        line_valid |-> outstanding != 3'd0)
    else begin
        fail_cnt++;
        $error("Line delivered with no request outstanding");
    end

    valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        accept && !line_valid |-> ##3 line_valid)
    else begin
        fail_cnt++;
        $error("Line not valid in time after an accepted request");
    end

    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        line_valid && !line_ready |=> line_valid && $stable(line_data))
    else begin
        fail_cnt++;
        $error("Line dropped or changed while stalled");
    end

endmodule

bind line_buffer_top line_buffer_asserts line_buffer_asserts_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_ack         (wb_ack),
    .line_req       (line_req),
    .line_req_ready (line_req_ready),
    .line_valid     (line_valid),
    .line_ready     (line_ready),
    .line_data      (line_data)
);

`default_nettype wire

// File: dv/line_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_buffer_consts.svh"

module line_buffer_tb;

    import mem_pkg::*;
    import bus_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_WORDS      = 48;
    localparam int WB_CYCLES    = 4;
    localparam int LINE_CYCLES  = 6;
    // Two write passes and one read pass, line reads, then margin
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + 3 * N_WORDS * WB_CYCLES
                                       + N_WORDS * LINE_CYCLES + 200);

    logic      clk = 1'b0;
    logic      arst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_adr_t   wb_adr;
    wb_dat_t   wb_dat_w;
    wb_sel_t   wb_sel;
    logic      wb_ack;
    wb_dat_t   wb_dat_r;
    logic      line_req;
    line_idx_t line_addr;
    logic      line_req_ready;
    logic      line_valid;
    line_t     line_data;
    logic      line_ready;

    // Reference model and expected values
    line_t       model [`LB_NUM_LINES] = '{default: '0};
    wb_adr_t     adr_list [N_WORDS];
    wb_dat_t     exp_word = '0;
    line_t       exp_ring [8];
    line_t       exp_head;
    int unsigned exp_rd = 0;
    int unsigned exp_wr = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    logic [15:0] lfsr = 16'd51;

    always #2 clk = ~clk;

    line_buffer_top line_buffer_top_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .wb_ack         (wb_ack),
        .wb_dat_r       (wb_dat_r),
        .line_req       (line_req),
        .line_addr      (line_addr),
        .line_req_ready (line_req_ready),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .line_ready     (line_ready)
    );

    // ==================================================
    // Helpers
    // ==================================================

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return errors + line_buffer_top_i.line_buffer_asserts_i.fail_cnt;
    endfunction

    // Word k of a line sits in bits 32k to 32k+31
    task automatic model_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
        line_idx_t idx;
        int        base;
        idx  = adr[WB_ADR_BITS-1:WORD_OFF_BITS];
        base = int'(adr[WORD_OFF_BITS-1:0]) * `LB_WORD_BITS;
        for (int b = 0; b < WB_SEL_BITS; b++) begin
            if (sel[b]) begin
                model[idx][base + b*8 +: 8] = dat[b*8 +: 8];
            end
        end
    endtask

    task automatic wb_start(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                            input wb_sel_t sel);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        if (we) begin
            model_write(adr, dat, sel);
        end else begin
            exp_word = model[adr[WB_ADR_BITS-1:WORD_OFF_BITS]]
                [int'(adr[WORD_OFF_BITS-1:0]) * `LB_WORD_BITS +: `LB_WORD_BITS];
        end
    endtask

    task automatic wb_finish();
        while (!wb_ack) @(negedge clk);
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                             input wb_sel_t sel);
        wb_start(we, adr, dat, sel);
        @(negedge clk);
        wb_finish();
    endtask

    task automatic line_request(input line_idx_t idx);
        line_req  = 1'b1;
        line_addr = idx;
        while (!line_req_ready) @(negedge clk);
        exp_ring[exp_wr[2:0]] = model[idx];
        exp_wr++;
        @(negedge clk);
        line_req = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_rd != exp_wr) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %-22s done, errors so far %0d", name, total_errors());
    endtask

    // ==================================================
    // Value checks
    // ==================================================

    assign exp_head = exp_ring[exp_rd[2:0]];

    word_read_value: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack && !wb_we |-> wb_dat_r == exp_word)
    else begin
        errors++;
        $error("FAILED wb_dat_r got %h expected %h", $sampled(wb_dat_r), $sampled(exp_word));
    end

    line_read_value: assert property (@(posedge clk) disable iff (!arst_n)
        line_valid && line_ready |-> line_data == exp_head)
    else begin
        errors++;
        $error("FAILED line_data got %h expected %h", $sampled(line_data), $sampled(exp_head));
    end

    // Consumption tracking and run limit
    always @(posedge clk) begin
        cycles++;
        if (arst_n && line_valid && line_ready) begin
            exp_rd <= exp_rd + 1;
            checks++;
        end
        if (arst_n && wb_ack && !wb_we) begin
            checks++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        wb_adr_t fwd_adr;
        arst_n     = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = '0;
        line_req   = 1'b0;
        line_addr  = '0;
        line_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        report_test("reset values");

        // Addresses fall in 16 lines so later writes land on old data
        for (int i = 0; i < N_WORDS; i++) begin
            adr_list[i] = wb_adr_t'(take_bits(7));
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < N_WORDS; i++) begin
                wb_access(1'b1, adr_list[i], take_bits(32), wb_sel_t'(take_bits(4)));
            end
        end
        for (int i = 0; i < N_WORDS; i++) begin
            wb_access(1'b0, adr_list[i], '0, '1);
        end
        report_test("word write and read");

        for (int i = 0; i < N_WORDS; i++) begin
            line_request(adr_list[i][WB_ADR_BITS-1:WORD_OFF_BITS]);
        end
        for (int i = 0; i < 8; i++) begin
            line_request(line_idx_t'(take_bits(7)));
        end
        wait_drain();
        report_test("line read");

        // Word write and line read of one line in the same cycle
        for (int i = 0; i < 4; i++) begin
            fwd_adr = adr_list[i];
            wb_start(1'b1, fwd_adr, take_bits(32), wb_sel_t'(take_bits(4)) | 4'b0001);
            line_req  = 1'b1;
            line_addr = fwd_adr[WB_ADR_BITS-1:WORD_OFF_BITS];
            exp_ring[exp_wr[2:0]] = model[line_addr];
            exp_wr++;
            @(negedge clk);
            line_req = 1'b0;
            wb_finish();
            wait_drain();
        end
        report_test("write forwarding");

        // Third request waits for credit until the consumer resumes
        line_ready = 1'b0;
        fork
            begin
                repeat (8) @(negedge clk);
                line_ready = 1'b1;
            end
            begin
                line_request(adr_list[4][WB_ADR_BITS-1:WORD_OFF_BITS]);
                line_request(adr_list[5][WB_ADR_BITS-1:WORD_OFF_BITS]);
                line_request(adr_list[6][WB_ADR_BITS-1:WORD_OFF_BITS]);
            end
        join
        wait_drain();
        report_test("back-pressure order");

        repeat (4) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/mem_pkg.sv
source/bus_pkg.sv
source/dual_port_ram.sv
source/wb_word_port.sv
source/line_read_port.sv
source/line_buffer_top.sv
dv/line_buffer_asserts.sv
dv/line_buffer_tb.sv

// File: source/bus_pkg.sv
`default_nettype none

`include "line_buffer_consts.svh"

package bus_pkg;

    // Byte lanes on the Wishbone data bus
    localparam int WB_SEL_BITS = `LB_WORD_BITS / `LB_WRITE_BITS;

    localparam int WORDS_PER_LINE = `LB_LINE_BITS / `LB_WORD_BITS;
    localparam int WORD_OFF_BITS  = $clog2(WORDS_PER_LINE);

    // Word address is line index on top, word offset below
    localparam int WB_ADR_BITS = $clog2(`LB_NUM_LINES) + WORD_OFF_BITS;

    typedef logic [WB_ADR_BITS-1:0]   wb_adr_t;
    typedef logic [`LB_WORD_BITS-1:0] wb_dat_t;
    typedef logic [WB_SEL_BITS-1:0]   wb_sel_t;
    typedef logic [WORD_OFF_BITS-1:0] word_off_t;

endpackage

`default_nettype wire

// File: source/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int WORD_BITS  = 256,
    parameter int NUM_WORDS  = 128,
    parameter int WRITE_BITS = 8
) (
    input  wire                              clk,
    input  wire                              arst_n,
    // Port 0, read or byte-masked write
    input  wire                              p0_en,
    input  wire                              p0_we,
    input  wire  [$clog2(NUM_WORDS)-1:0]     p0_addr,
    input  wire  [WORD_BITS-1:0]             p0_wdata,
    input  wire  [WORD_BITS/WRITE_BITS-1:0]  p0_mask,
    output logic [WORD_BITS-1:0]             p0_rdata,
    // Port 1, read only
    input  wire                              p1_en,
    input  wire  [$clog2(NUM_WORDS)-1:0]     p1_addr,
    output logic [WORD_BITS-1:0]             p1_rdata
);

    localparam int ADDR_BITS = $clog2(NUM_WORDS);
    localparam int MASK_BITS = WORD_BITS / WRITE_BITS;

    // Contents start at zero
    logic [WORD_BITS-1:0] mem [NUM_WORDS] = '{default: '0};

    logic                 en0_q;
    logic                 en1_q;
    logic                 we0_q;
    logic [ADDR_BITS-1:0] addr0_q;
    logic [ADDR_BITS-1:0] addr1_q;
    logic [WORD_BITS-1:0] wdata0_q;
    logic [MASK_BITS-1:0] mask0_q;
    logic                 fwd;

    // ==================================================
    // Request registers
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en0_q <= 1'b0;
            en1_q <= 1'b0;
        end else begin
            en0_q <= p0_en;
            en1_q <= p1_en;
        end
    end

    always_ff @(posedge clk) begin
        we0_q    <= p0_we;
        addr0_q  <= p0_addr;
        addr1_q  <= p1_addr;
        wdata0_q <= p0_wdata;
        mask0_q  <= p0_mask;
    end

    // ==================================================
    // Array access
    // ==================================================

    always_ff @(posedge clk) begin
        if (en0_q && we0_q) begin
            for (int i = 0; i < MASK_BITS; i++) begin
                if (mask0_q[i]) begin
                    mem[addr0_q][i*WRITE_BITS +: WRITE_BITS] <=
                        wdata0_q[i*WRITE_BITS +: WRITE_BITS];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p0_rdata <= '0;
        end else if (en0_q && !we0_q) begin
            p0_rdata <= mem[addr0_q];
        end
    end

    // Port 1 sees a same-line port 0 write in the same access
    assign fwd = en0_q && we0_q && en1_q && (addr0_q == addr1_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p1_rdata <= '0;
        end else if (en1_q) begin
            p1_rdata <= mem[addr1_q];
            // Written bytes override the old line contents
            for (int i = 0; i < MASK_BITS; i++) begin
                if (fwd && mask0_q[i]) begin
                    p1_rdata[i*WRITE_BITS +: WRITE_BITS] <=
                        wdata0_q[i*WRITE_BITS +: WRITE_BITS];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/line_buffer_consts.svh
`ifndef LINE_BUFFER_CONSTS_SVH
`define LINE_BUFFER_CONSTS_SVH

// ==================================================
// Line buffer geometry
// ==================================================

// Number of lines held in the RAM
`define LB_NUM_LINES 128

// Width of one line in bits
`define LB_LINE_BITS 256

// Smallest writable unit, one byte
`define LB_WRITE_BITS 8

// Wishbone data bus width
`define LB_WORD_BITS 32

`endif

// File: source/line_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_buffer_consts.svh"

module line_buffer_top (
    input  wire                      clk,
    input  wire                      arst_n,
    // Wishbone classic slave
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire bus_pkg::wb_adr_t    wb_adr,
    input  wire bus_pkg::wb_dat_t    wb_dat_w,
    input  wire bus_pkg::wb_sel_t    wb_sel,
    output logic                     wb_ack,
    output bus_pkg::wb_dat_t         wb_dat_r,
    // Line stream
    input  wire                      line_req,
    input  wire mem_pkg::line_idx_t  line_addr,
    output logic                     line_req_ready,
    output logic                     line_valid,
    output mem_pkg::line_t           line_data,
    input  wire                      line_ready
);

    // RAM port 0
    logic                p0_en;
    logic                p0_we;
    mem_pkg::line_idx_t  p0_addr;
    mem_pkg::line_t      p0_wdata;
    mem_pkg::line_mask_t p0_mask;
    mem_pkg::line_t      p0_rdata;

    // RAM port 1
    logic                p1_en;
    mem_pkg::line_idx_t  p1_addr;
    mem_pkg::line_t      p1_rdata;

    wb_word_port wb_word_port_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .p0_en    (p0_en),
        .p0_we    (p0_we),
        .p0_addr  (p0_addr),
        .p0_wdata (p0_wdata),
        .p0_mask  (p0_mask),
        .p0_rdata (p0_rdata)
    );

    line_read_port line_read_port_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .line_req       (line_req),
        .line_addr      (line_addr),
        .line_req_ready (line_req_ready),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .line_ready     (line_ready),
        .p1_en          (p1_en),
        .p1_addr        (p1_addr),
        .p1_rdata       (p1_rdata)
    );

    dual_port_ram #(
        .WORD_BITS  (`LB_LINE_BITS),
        .NUM_WORDS  (`LB_NUM_LINES),
        .WRITE_BITS (`LB_WRITE_BITS)
    ) dual_port_ram_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .p0_en    (p0_en),
        .p0_we    (p0_we),
        .p0_addr  (p0_addr),
        .p0_wdata (p0_wdata),
        .p0_mask  (p0_mask),
        .p0_rdata (p0_rdata),
        .p1_en    (p1_en),
        .p1_addr  (p1_addr),
        .p1_rdata (p1_rdata)
    );

endmodule

`default_nettype wire

// File: source/line_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module line_read_port (
    input  wire                     clk,
    input  wire                     arst_n,
    // Line request stream
    input  wire                     line_req,
    input  wire mem_pkg::line_idx_t line_addr,
    output logic                    line_req_ready,
    // Line response stream
    output logic                    line_valid,
    output mem_pkg::line_t          line_data,
    input  wire                     line_ready,
    // RAM port 1
    output logic                    p1_en,
    output mem_pkg::line_idx_t      p1_addr,
    input  wire mem_pkg::line_t     p1_rdata
);

    import mem_pkg::*;

    logic       accept;
    logic       rd_s1;
    logic       rd_s2;
    logic [1:0] credit_used;
    logic       push;
    logic       pop;
    line_t      fifo_mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] fifo_cnt;

    // ==================================================
    // Request side
    // ==================================================

    // Reads in flight plus held lines never exceed the FIFO depth
    assign credit_used    = 2'(rd_s1) + 2'(rd_s2) + fifo_cnt;
    assign line_req_ready = credit_used < 2'd2;
    assign accept         = line_req && line_req_ready;

    assign p1_en   = accept;
    assign p1_addr = line_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_s1 <= 1'b0;
            rd_s2 <= 1'b0;
        end else begin
            rd_s1 <= accept;
            rd_s2 <= rd_s1;
        end
    end

    // ==================================================
    // Holding FIFO
    // ==================================================

    // p1_rdata is valid in the cycle rd_s2 is set
    assign push = rd_s2;
    assign pop  = line_valid && line_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= p1_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            fifo_cnt <= 2'd0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop)  rd_ptr <= !rd_ptr;
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 2'd1;
                2'b01:   fifo_cnt <= fifo_cnt - 2'd1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    assign line_valid = fifo_cnt != 2'd0;
    assign line_data  = fifo_mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

`include "line_buffer_consts.svh"

package mem_pkg;

    // ==================================================
    // Derived line memory counts
    // ==================================================

    localparam int LINE_IDX_BITS = $clog2(`LB_NUM_LINES);

    // One mask bit per writable byte of a line
    localparam int LINE_BYTES = `LB_LINE_BITS / `LB_WRITE_BITS;

    // ==================================================
    // Line memory types
    // ==================================================

    typedef logic [LINE_IDX_BITS-1:0] line_idx_t;

    typedef logic [`LB_LINE_BITS-1:0] line_t;

    typedef logic [LINE_BYTES-1:0] line_mask_t;

endpackage

`default_nettype wire

// File: source/wb_word_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_word_port (
    input  wire                  clk,
    input  wire                  arst_n,
    // Wishbone classic slave
    input  wire                  wb_cyc,
    input  wire                  wb_stb,
    input  wire                  wb_we,
    input  wire bus_pkg::wb_adr_t wb_adr,
    input  wire bus_pkg::wb_dat_t wb_dat_w,
    input  wire bus_pkg::wb_sel_t wb_sel,
    output logic                 wb_ack,
    output bus_pkg::wb_dat_t     wb_dat_r,
    // RAM port 0
    output logic                 p0_en,
    output logic                 p0_we,
    output mem_pkg::line_idx_t   p0_addr,
    output mem_pkg::line_t       p0_wdata,
    output mem_pkg::line_mask_t  p0_mask,
    input  wire mem_pkg::line_t  p0_rdata
);

    import bus_pkg::*;
    import mem_pkg::*;

    logic      req;
    logic      busy_1;
    logic      busy_2;
    word_off_t off;
    word_off_t off_q;

    // ==================================================
    // Request decode
    // ==================================================

    assign off = word_off_t'(wb_adr);

    // Issue only once per strobe, blocked until the ack cycle has passed
    assign req = wb_cyc && wb_stb && !busy_1 && !busy_2;

    assign p0_en   = req;
    assign p0_we   = wb_we;
    assign p0_addr = line_idx_t'(wb_adr >> WORD_OFF_BITS);

    // Same word in every slot, the mask picks the target slot
    assign p0_wdata = {WORDS_PER_LINE{wb_dat_w}};
    assign p0_mask  = line_mask_t'(wb_sel) << (off * WB_SEL_BITS);

    // ==================================================
    // Busy pipeline and ack
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_1 <= 1'b0;
            busy_2 <= 1'b0;
        end else begin
            busy_1 <= req;
            busy_2 <= busy_1;
        end
    end

    // Offset kept for the read word select
    always_ff @(posedge clk) begin
        if (req) begin
            off_q <= off;
        end
    end

    // RAM data is valid in the second cycle after the request
    assign wb_ack   = busy_2 && wb_cyc && wb_stb;
    assign wb_dat_r = p0_rdata[off_q * $bits(wb_dat_t) +: $bits(wb_dat_t)];

endmodule

`default_nettype wire
